// File: design/ulpi_pkg.sv
package ulpi_pkg;

  // ULPI command codes in the upper two bits of a link byte
  typedef enum logic [1:0] {
    CMD_SPECIAL  = 2'b00,
    CMD_TRANSMIT = 2'b01,
    CMD_REG_WR   = 2'b10,
    CMD_REG_RD   = 2'b11
  } ulpi_cmd_e;

  // PID view, check nibble above the PID
  typedef struct packed {
    logic [3:0] check;
    logic [3:0] pid;
  } pid_view_t;

  // Link command view
  typedef struct packed {
    ulpi_cmd_e  code;
    logic [5:0] payload;
  } cmd_view_t;

  // One bus byte, read either as a PID or as a command
  typedef union packed {
    pid_view_t tok;
    cmd_view_t cmd;
  } ulpi_byte_u;

  typedef struct packed {
    logic       valid;
    logic       last;
    logic [7:0] data;
  } byte_stream_t;

  // Reported with the last beat of a received packet
  typedef struct packed {
    logic pid_err;
    logic abort;
  } rx_status_t;

  // Check nibble must be the inverse of the PID
  function automatic logic pid_ok(ulpi_byte_u b);
    return b.tok.check == ~b.tok.pid;
  endfunction

  // Full PID byte from a bare 4-bit PID
  function automatic ulpi_byte_u make_pid_byte(logic [3:0] pid);
    ulpi_byte_u b;
    b.tok.check = ~pid;
    b.tok.pid   = pid;
    return b;
  endfunction

  // Transmit command carrying the PID in its low bits
  function automatic ulpi_byte_u make_tx_cmd(logic [3:0] pid);
    ulpi_byte_u b;
    b.cmd.code    = CMD_TRANSMIT;
    b.cmd.payload = {2'b00, pid};
    return b;
  endfunction

endpackage

// File: design/ulpi_phy_emu.sv
`timescale 1ns/1ps

module ulpi_phy_emu import ulpi_pkg::*; #(
  parameter int DATA_W = 8
) (
  input  logic         clock,
  input  logic         rst_n_i,
  input  logic         stp_i,
  input  ulpi_byte_u   link_data_i,
  input  byte_stream_t line_in_i,
  input  logic         line_out_ready_i,
  output logic         dir_o,
  output logic         nxt_o,
  output ulpi_byte_u   phy_data_o,
  output logic         line_in_ready_o,
  output byte_stream_t line_out_o
);

  localparam int NIB_W = DATA_W / 2;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SEND,
    ST_RECV,
    ST_STOP
  } state_e;

  state_e            state_q;
  logic              dir_q;
  logic              dir_d;
  logic              nxt_q;
  logic              cmd_pend_q;
  logic              pend_valid_q;
  logic [DATA_W-1:0] pend_data_q;
  byte_stream_t      out_q;

  logic             turn;
  logic             tx_cmd;
  logic             send_nxt;
  logic             take;
  logic             out_room;
  logic             move;
  logic             out_busy_next;
  logic [NIB_W-1:0] cmd_pid;

  assign turn   = dir_q != dir_d;
  assign tx_cmd = link_data_i.cmd.code == CMD_TRANSMIT;
  assign cmd_pid = link_data_i.cmd.payload[NIB_W-1:0];

  // Line-in bytes go straight onto the bus, one per cycle with nxt
  assign send_nxt        = (state_q == ST_SEND) && !turn && line_in_i.valid;
  assign line_in_ready_o = send_nxt;
  assign phy_data_o      = line_in_i.data;
  assign dir_o           = dir_q;
  assign nxt_o           = send_nxt || nxt_q;
  assign line_out_o      = out_q;

  always_comb begin
    out_room = !out_q.valid || line_out_ready_i;
    take     = (state_q == ST_RECV) && nxt_q && !stp_i;
    // Pending byte leaves when its successor arrives or at stp
    move     = (take && !cmd_pend_q && pend_valid_q) ||
               ((state_q == ST_STOP) && out_room && pend_valid_q);
    out_busy_next = move || (out_q.valid && !line_out_ready_i);
  end

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q      <= ST_IDLE;
      dir_q        <= 1'b0;
      dir_d        <= 1'b0;
      nxt_q        <= 1'b0;
      cmd_pend_q   <= 1'b0;
      pend_valid_q <= 1'b0;
      out_q        <= '0;
    end else begin
      dir_d <= dir_q;

      if (move) begin
        out_q.valid <= 1'b1;
        out_q.last  <= (state_q == ST_STOP);
        out_q.data  <= pend_data_q;
      end else if (out_q.valid && line_out_ready_i) begin
        out_q.valid <= 1'b0;
      end

      case (state_q)
        ST_IDLE: begin
          if (line_in_i.valid) begin
            // Receive has precedence over a waiting TX command
            dir_q   <= 1'b1;
            state_q <= ST_SEND;
          end else if (!turn && tx_cmd) begin
            state_q      <= ST_RECV;
            cmd_pend_q   <= 1'b1;
            pend_valid_q <= 1'b1;
            nxt_q        <= !out_busy_next;
          end
        end

        ST_SEND: begin
          if (send_nxt && line_in_i.last) begin
            dir_q   <= 1'b0;
            state_q <= ST_IDLE;
          end
        end

        ST_RECV: begin
          if (stp_i) begin
            nxt_q   <= 1'b0;
            state_q <= ST_STOP;
          end else begin
            nxt_q <= !out_busy_next;
            if (take) begin
              cmd_pend_q <= 1'b0;
            end
          end
        end

        default: begin
          // Flush the held byte as the last one
          if (move) begin
            pend_valid_q <= 1'b0;
            state_q      <= ST_IDLE;
          end
        end
      endcase
    end
  end

  // Held byte, restored PID first, then payload
  always_ff @(posedge clock) begin
    if ((state_q == ST_IDLE) && !line_in_i.valid && !turn && tx_cmd) begin
      pend_data_q <= {~cmd_pid, cmd_pid};
    end else if (take && !cmd_pend_q) begin
      pend_data_q <= link_data_i;
    end
  end

  assert property (@(posedge clock) disable iff (!rst_n_i)
    (dir_q && !dir_d) |-> !nxt_o)
    else $error("nxt raised in turnaround after dir rise");

endmodule

// File: design/ulpi_link_tx.sv
`timescale 1ns/1ps

module ulpi_link_tx import ulpi_pkg::*; #(
  parameter int DATA_W = 8
) (
  input  logic         clock,
  input  logic         rst_n_i,
  input  byte_stream_t host_tx_i,
  input  logic         dir_i,
  input  logic         nxt_i,
  output logic         host_tx_ready_o,
  output ulpi_byte_u   link_data_o,
  output logic         stp_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CMD,
    ST_DATA
  } state_e;

  state_e     state_q;
  logic       armed_q;
  logic       stp_q;
  logic       last_q;
  ulpi_byte_u cmd_q;

  logic                  accept;
  logic [DATA_W/2-1:0]   pid_w;

  assign pid_w = host_tx_i.data[DATA_W/2-1:0];

  // Payload moves only in cycles where the PHY signals nxt
  always_comb begin
    case (state_q)
      ST_IDLE: host_tx_ready_o = armed_q && !dir_i && !stp_q;
      ST_DATA: host_tx_ready_o = nxt_i && !dir_i;
      default: host_tx_ready_o = 1'b0;
    endcase
  end

  assign accept = host_tx_i.valid && host_tx_ready_o;

  // The host keeps valid high within a packet, so the bus byte is always real
  always_comb begin
    case (state_q)
      ST_CMD:  link_data_o = cmd_q;
      ST_DATA: link_data_o = host_tx_i.data;
      default: link_data_o = '0;
    endcase
  end

  assign stp_o = stp_q;

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      armed_q <= 1'b0;
      stp_q   <= 1'b0;
      last_q  <= 1'b0;
      cmd_q   <= '0;
    end else begin
      armed_q <= 1'b1;
      stp_q   <= 1'b0;

      case (state_q)
        ST_IDLE: begin
          if (accept) begin
            cmd_q   <= make_tx_cmd(pid_w);
            last_q  <= host_tx_i.last;
            state_q <= ST_CMD;
          end
        end

        ST_CMD: begin
          // While dir is high the command just waits for the bus
          if (nxt_i && !dir_i) begin
            if (last_q) begin
              stp_q   <= 1'b1;
              state_q <= ST_IDLE;
            end else begin
              state_q <= ST_DATA;
            end
          end
        end

        default: begin
          if (accept && host_tx_i.last) begin
            stp_q   <= 1'b1;
            state_q <= ST_IDLE;
          end
        end
      endcase
    end
  end

  assert property (@(posedge clock) disable iff (!rst_n_i)
    stp_o |-> !dir_i)
    else $error("stp driven while PHY owns the bus");

endmodule

// File: design/ulpi_link_rx.sv
`timescale 1ns/1ps

module ulpi_link_rx import ulpi_pkg::*; #(
  parameter int DATA_W = 8
) (
  input  logic         clock,
  input  logic         rst_n_i,
  input  logic         dir_i,
  input  logic         nxt_i,
  input  ulpi_byte_u   phy_data_i,
  input  logic         host_rx_ready_i,
  output byte_stream_t host_rx_o,
  output rx_status_t   rx_status_o
);

  logic              dir_d;
  logic              first_q;
  logic              h_valid;
  logic              h_last;
  logic              h_err;
  logic              h_abort;
  logic [DATA_W-1:0] h_data;
  byte_stream_t      out_q;
  rx_status_t        status_q;

  logic turn;
  logic take;
  logic out_free;
  logic release_h;
  logic rel_last;

  assign turn     = dir_i != dir_d;
  assign take     = dir_i && !turn && nxt_i;
  assign out_free = !out_q.valid || host_rx_ready_i;

  // Held byte goes out when the next one arrives or once dir is low
  assign release_h = h_valid && (take || (!dir_i && out_free));
  assign rel_last  = h_last || !dir_i;

  assign host_rx_o   = out_q;
  assign rx_status_o = status_q;

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dir_d    <= 1'b0;
      first_q  <= 1'b0;
      h_valid  <= 1'b0;
      h_last   <= 1'b0;
      h_err    <= 1'b0;
      h_abort  <= 1'b0;
      out_q    <= '0;
      status_q <= '0;
    end else begin
      dir_d <= dir_i;

      if (out_q.valid && host_rx_ready_i) begin
        out_q.valid <= 1'b0;
      end

      if (release_h) begin
        out_q.valid <= 1'b1;
        out_q.last  <= rel_last;
        out_q.data  <= h_data;
        status_q    <= rel_last ? '{pid_err: h_err, abort: h_abort} : '0;
        h_valid     <= 1'b0;
      end

      if (!dir_i && h_valid) begin
        h_last <= 1'b1;
      end

      // New packet began before the old last beat got out
      if (dir_i && !dir_d) begin
        first_q <= 1'b1;
        if (h_valid) begin
          h_abort <= 1'b1;
        end
      end

      if (take) begin
        h_valid <= 1'b1;
        h_last  <= 1'b0;
        h_abort <= 1'b0;
        first_q <= 1'b0;
        if (first_q) begin
          h_err <= !pid_ok(phy_data_i);
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (take) begin
      h_data <= phy_data_i;
    end
  end

  assert property (@(posedge clock) disable iff (!rst_n_i)
    $rose(host_rx_o.valid) |-> !$past(dir_i && turn))
    else $error("host_rx valid raised from a turnaround cycle");

endmodule

// File: design/ulpi_loopback_top.sv
`timescale 1ns/1ps

module ulpi_loopback_top import ulpi_pkg::*; #(
  parameter int DATA_W = 8
) (
  input  logic         clock,
  input  logic         rst_n_i,
  input  byte_stream_t host_tx_i,
  input  logic         host_rx_ready_i,
  input  byte_stream_t line_in_i,
  input  logic         line_out_ready_i,
  output logic         host_tx_ready_o,
  output byte_stream_t host_rx_o,
  output rx_status_t   rx_status_o,
  output logic         line_in_ready_o,
  output byte_stream_t line_out_o
);

  logic         dir;
  logic         nxt;
  logic         stp;
  ulpi_byte_u   phy_data;
  ulpi_byte_u   link_data;
  ulpi_byte_u   ulpi_data;
  byte_stream_t phy_line_in;
  logic         phy_in_ready;

  // dir picks which one-way bus carries the data
  assign ulpi_data = dir ? phy_data : link_data;

  // Receive stalls at the PHY while the host side is not ready
  always_comb begin
    phy_line_in       = line_in_i;
    phy_line_in.valid = line_in_i.valid && host_rx_ready_i;
  end

  assign line_in_ready_o = phy_in_ready && host_rx_ready_i;

  ulpi_link_tx #(.DATA_W(DATA_W)) u_link_tx (
    .clock           (clock),
    .rst_n_i         (rst_n_i),
    .host_tx_i       (host_tx_i),
    .dir_i           (dir),
    .nxt_i           (nxt),
    .host_tx_ready_o (host_tx_ready_o),
    .link_data_o     (link_data),
    .stp_o           (stp)
  );

  ulpi_link_rx #(.DATA_W(DATA_W)) u_link_rx (
    .clock           (clock),
    .rst_n_i         (rst_n_i),
    .dir_i           (dir),
    .nxt_i           (nxt),
    .phy_data_i      (ulpi_data),
    .host_rx_ready_i (host_rx_ready_i),
    .host_rx_o       (host_rx_o),
    .rx_status_o     (rx_status_o)
  );

  ulpi_phy_emu #(.DATA_W(DATA_W)) u_phy_emu (
    .clock            (clock),
    .rst_n_i          (rst_n_i),
    .stp_i            (stp),
    .link_data_i      (ulpi_data),
    .line_in_i        (phy_line_in),
    .line_out_ready_i (line_out_ready_i),
    .dir_o            (dir),
    .nxt_o            (nxt),
    .phy_data_o       (phy_data),
    .line_in_ready_o  (phy_in_ready),
    .line_out_o       (line_out_o)
  );

endmodule

// File: verification/tb_ulpi_loopback.sv
`timescale 1ns/1ps

module tb_ulpi_loopback import ulpi_pkg::*; ();

  localparam int CLK_PERIOD = 20;
  localparam int REC_CYCLES = 200;

  logic         clock;
  logic         rst_n_i;
  byte_stream_t host_tx_i;
  logic         host_rx_ready_i;
  byte_stream_t line_in_i;
  logic         line_out_ready_i;
  logic         host_tx_ready_o;
  byte_stream_t host_rx_o;
  rx_status_t   rx_status_o;
  logic         line_in_ready_o;
  byte_stream_t line_out_o;

  logic [7:0]   vec_mem [0:255];
  int           ptr;
  int           n_records;
  integer       seed;
  logic         hold_rx;

  // Current record contents
  logic [7:0]   tx_pkt [$];
  logic [7:0]   tx_first;
  logic [7:0]   rx_pkt [$];
  rx_status_t   rx_exp_status;

  // Beats seen by the monitor
  byte_stream_t out_beat_q [$];
  time          out_time_q [$];
  byte_stream_t rx_beat_q [$];
  rx_status_t   rx_stat_q [$];
  time          first_out_time;
  time          rx_last_time;

  ulpi_loopback_top #(.DATA_W(8)) dut (
    .clock            (clock),
    .rst_n_i          (rst_n_i),
    .host_tx_i        (host_tx_i),
    .host_rx_ready_i  (host_rx_ready_i),
    .line_in_i        (line_in_i),
    .line_out_ready_i (line_out_ready_i),
    .host_tx_ready_o  (host_tx_ready_o),
    .host_rx_o        (host_rx_o),
    .rx_status_o      (rx_status_o),
    .line_in_ready_o  (line_in_ready_o),
    .line_out_o       (line_out_o)
  );

  always #(CLK_PERIOD / 2) clock = ~clock;

  // Downstream readies, high about three quarters of the time
  always @(posedge clock) begin
    if (rst_n_i) begin
      line_out_ready_i <= ($random(seed) & 3) != 0;
      host_rx_ready_i  <= hold_rx ? 1'b1 : (($random(seed) & 3) != 0);
    end
  end

  always @(posedge clock) begin
    if (rst_n_i) begin
      if (line_out_o.valid && line_out_ready_i) begin
        out_beat_q.push_back(line_out_o);
        out_time_q.push_back($time);
      end
      if (host_rx_o.valid && host_rx_ready_i) begin
        rx_beat_q.push_back(host_rx_o);
        rx_stat_q.push_back(rx_status_o);
      end
    end
  end

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "testbench stopped at first error");
  endtask

  task automatic check_stream(input string name, input byte_stream_t got,
                              input byte_stream_t exp);
    if (got !== exp) begin
      $display("error: %s got %h expected %h", name, got, exp);
      stop_on_error("stream beat mismatch");
    end
  endtask

  task automatic check_status(input string name, input rx_status_t got,
                              input rx_status_t exp);
    if (got !== exp) begin
      $display("error: %s got %h expected %h", name, got, exp);
      stop_on_error("receive status mismatch");
    end
  endtask

  // Record layout is tag, then per body a length, the bytes and one expected byte
  task count_records;
    int idx;
    idx = 0;
    n_records = 0;
    while (vec_mem[idx] !== 8'hff && idx < 250) begin
      if (vec_mem[idx] == 8'h02) begin
        idx = idx + 1;
        idx = idx + vec_mem[idx] + 2;
        idx = idx + vec_mem[idx] + 2;
      end else begin
        idx = idx + 1;
        idx = idx + vec_mem[idx] + 2;
      end
      n_records = n_records + 1;
    end
  endtask

  task load_tx;
    int len;
    int i;
    len = vec_mem[ptr];
    ptr = ptr + 1;
    tx_pkt.delete();
    for (i = 0; i < len; i++) begin
      tx_pkt.push_back(vec_mem[ptr]);
      ptr = ptr + 1;
    end
    tx_first = vec_mem[ptr];
    ptr = ptr + 1;
  endtask

  task load_rx;
    int len;
    int i;
    len = vec_mem[ptr];
    ptr = ptr + 1;
    rx_pkt.delete();
    for (i = 0; i < len; i++) begin
      rx_pkt.push_back(vec_mem[ptr]);
      ptr = ptr + 1;
    end
    rx_exp_status = vec_mem[ptr][1:0];
    ptr = ptr + 1;
  endtask

  // Valid stays high for the whole packet
  task drive_host;
    int i;
    for (i = 0; i < tx_pkt.size(); i++) begin
      host_tx_i <= {1'b1, i == tx_pkt.size() - 1, tx_pkt[i]};
      @(posedge clock);
      while (!host_tx_ready_o) @(posedge clock);
    end
    host_tx_i <= '0;
  endtask

  task drive_line_in;
    int i;
    for (i = 0; i < rx_pkt.size(); i++) begin
      line_in_i <= {1'b1, i == rx_pkt.size() - 1, rx_pkt[i]};
      @(posedge clock);
      while (!line_in_ready_o) @(posedge clock);
    end
    rx_last_time = $time;
    line_in_i <= '0;
  endtask

  // First line byte is the restored PID, the rest pass unchanged
  task collect_line_out;
    byte_stream_t got;
    byte_stream_t exp_beat;
    time          got_time;
    logic [7:0]   exp_data;
    int           i;
    for (i = 0; i < tx_pkt.size(); i++) begin
      while (out_beat_q.size() == 0) @(posedge clock);
      got      = out_beat_q.pop_front();
      got_time = out_time_q.pop_front();
      if (i == 0) begin
        first_out_time = got_time;
      end
      exp_data = (i == 0) ? tx_first : tx_pkt[i];
      exp_beat = {1'b1, i == tx_pkt.size() - 1, exp_data};
      check_stream("line_out_o", got, exp_beat);
    end
  endtask

  task collect_host_rx;
    byte_stream_t got;
    byte_stream_t exp_beat;
    rx_status_t   got_stat;
    rx_status_t   exp_stat;
    int           i;
    for (i = 0; i < rx_pkt.size(); i++) begin
      while (rx_beat_q.size() == 0) @(posedge clock);
      got      = rx_beat_q.pop_front();
      got_stat = rx_stat_q.pop_front();
      exp_beat = {1'b1, i == rx_pkt.size() - 1, rx_pkt[i]};
      exp_stat = (i == rx_pkt.size() - 1) ? rx_exp_status : 2'b00;
      check_stream("host_rx_o", got, exp_beat);
      check_status("rx_status_o", got_stat, exp_stat);
    end
  endtask

  initial begin
    clock            = 1'b0;
    rst_n_i          = 1'b0;
    host_tx_i        = '0;
    line_in_i        = '0;
    host_rx_ready_i  = 1'b0;
    line_out_ready_i = 1'b0;
    hold_rx          = 1'b0;
    seed             = 22804;
    $readmemh("verification/ulpi_vectors.hex", vec_mem);
    count_records();
    repeat (2) @(posedge clock);
    rst_n_i <= 1'b1;
    repeat (2) @(posedge clock);

    ptr = 0;
    while (vec_mem[ptr] !== 8'hff && ptr < 250) begin
      ptr = ptr + 1;
      case (vec_mem[ptr-1])
        8'h00: begin
          load_tx();
          fork
            drive_host();
            collect_line_out();
          join
        end
        8'h01: begin
          load_rx();
          fork
            drive_line_in();
            collect_host_rx();
          join
        end
        8'h02: begin
          load_rx();
          load_tx();
          // Host side stays ready while the line-in packet is on the bus
          hold_rx <= 1'b1;
          @(posedge clock);
          fork
            drive_host();
            begin
              // Line-in shows up in the cycle the TX command is pending
              @(posedge clock);
              while (!host_tx_ready_o) @(posedge clock);
              drive_line_in();
            end
            collect_host_rx();
            collect_line_out();
          join
          hold_rx <= 1'b0;
          if (first_out_time <= rx_last_time) begin
            stop_on_error("host packet reached line_out before the line-in packet ended");
          end
        end
        default: begin
          stop_on_error("unknown record tag in vector file");
        end
      endcase
    end

    // Idle tail so stray beats can show up
    repeat (20) @(posedge clock);
    if (out_beat_q.size() == 0 && rx_beat_q.size() == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      $display("unexpected extra beats after the last record");
      $display("=== FAIL ===");
      $fatal(1, "extra output beats");
    end
  end

  initial begin
    wait (n_records > 0);
    #(n_records * REC_CYCLES * CLK_PERIOD);
    $display("watchdog expired before all records completed");
    $display("=== FAIL ===");
    $fatal(1, "timeout");
  end

endmodule

// File: verification/ulpi_vectors.hex
// tag len bytes... expect | tag 00 host to line, expect restored PID byte
// tag 01 line to host, expect status {pid_err, abort} | tag 02 line-in body then host body
00 04 03 11 22 33 C3
00 01 02 D2
01 05 4B A0 A1 A2 A3 00
00 06 5B 01 02 03 04 05 4B
01 03 33 7E 7F 02
01 01 D2 00
00 08 09 F0 E1 D2 C3 B4 A5 96 69
01 08 C3 10 20 30 40 50 60 70 00
01 04 4C 55 66 77 02
02 03 4B DE AD 00 04 01 BE EF 77 E1
00 03 0A 00 FF 5A
01 02 E1 5A 00
02 02 3D 01 02 05 0D 99 88 77 66 2D
// end marker
FF

// File: compile.f
design/ulpi_pkg.sv
design/ulpi_phy_emu.sv
design/ulpi_link_tx.sv
design/ulpi_link_rx.sv
design/ulpi_loopback_top.sv
verification/tb_ulpi_loopback.sv
